// File: build.f
verilog/nurnPkg.sv
verilog/inSpikeBuf.sv
verilog/configMem.sv
verilog/statusMem.sv
verilog/nurnCtrlr.sv
verilog/dataPath.sv
verilog/neuronCore.sv
sim/neuronCoreTb.sv

// File: run.sh
#!/bin/sh
# compile the neuron core testbench with Verilator and run it
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert --top-module neuronCoreTb \
		-Mdir obj_dir -f build.f &&
	./obj_dir/VneuronCoreTb ||
	{ echo "neuron core simulation did not pass"; exit 1; }

// File: sim/neuronCoreTb.sv
//----------------------------------------
// testbench for the neuron core; random
// weights, parameters and spikes from a
// fixed seed, checked against a model
//----------------------------------------
`default_nettype none

module neuronCoreTb import nurnPkg::*; ();

	localparam int CLK_PERIOD  = 4;
	localparam int STEP_CYCLES = NUM_NURNS * (NUM_AXONS + 2);
	localparam int STEP_BUDGET = 60;
	localparam int MAX_STEPS   = 60;
	localparam int MAX_CFG_WR  = 200;
	localparam int WATCHDOG_CYCLES = MAX_STEPS * STEP_BUDGET + 2 * MAX_CFG_WR + 100;
	localparam int SEED        = 32'h33121f9c;
	// 1.0 in 8.8 fixed point
	localparam int ONE         = 256;

	logic     clk_i;
	logic     arstN_i;
	logic     start_i;
	spikeVecT inSpike_i;
	cfgWrT    cfgWr_i;
	logic     busy_o;
	logic     done_o;
	logic     spikeValid_o;
	spikePktT spikePkt_o;

	// reference model state
	potT      mWeight [NUM_NURNS][NUM_AXONS];
	nurnCfgT  mCfg [NUM_NURNS];
	potT      mPot [NUM_NURNS];
	spikePktT expQ [$];
	spikePktT gotQ [$];
	int       stepCount;
	int       doneCount;
	string    curTest;

	neuronCore neuronCore_i (
		.clk_i        (clk_i),
		.arstN_i      (arstN_i),
		.start_i      (start_i),
		.inSpike_i    (inSpike_i),
		.cfgWr_i      (cfgWr_i),
		.busy_o       (busy_o),
		.done_o       (done_o),
		.spikeValid_o (spikeValid_o),
		.spikePkt_o   (spikePkt_o)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	//----------------------------------------
	// failure reporting and compares
	//----------------------------------------
	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic checkPkt(input spikePktT expected, input spikePktT actual);
		if (actual !== expected) begin
			failRun($sformatf("error %s: packet expected %h actual %h",
				curTest, expected, actual));
		end
	endtask

	// packets seen in one step
	task automatic checkDone(input nurnIdT expected, input nurnIdT actual);
		if (actual !== expected) begin
			failRun($sformatf("error %s: packet count expected %0d actual %0d",
				curTest, expected, actual));
		end
	endtask

	//----------------------------------------
	// reference model
	//----------------------------------------
	function automatic potT satAdd(input potT a, input potT b);
		int s;
		s = int'(a) + int'(b);
		if (s > int'(POT_MAX)) begin
			return POT_MAX;
		end else if (s < int'(POT_MIN)) begin
			return POT_MIN;
		end
		return potT'(s);
	endfunction

	// bias first, then weights in axon order, then the threshold test
	task automatic modelStep(input spikeVecT spikes);
		potT      acc;
		potT      thr;
		spikePktT pkt;
		expQ.delete();
		for (int n = 0; n < NUM_NURNS; n++) begin
			acc = satAdd(mPot[n], mCfg[n].bias);
			for (int a = 0; a < NUM_AXONS; a++) begin
				if (spikes[a]) begin
					acc = satAdd(acc, mWeight[n][a]);
				end
			end
			thr = mCfg[n].threshold;
			if (acc >= thr) begin
				pkt.coreX    = CORE_X;
				pkt.coreY    = CORE_Y;
				pkt.reserved = '0;
				pkt.nurnId   = nurnIdT'(n);
				expQ.push_back(pkt);
				mPot[n] = mCfg[n].rstPot;
			end else begin
				mPot[n] = acc;
			end
		end
	endtask

	//----------------------------------------
	// stimulus
	//----------------------------------------
	task automatic resetDut();
		@(negedge clk_i);
		arstN_i   = 1'b0;
		start_i   = 1'b0;
		inSpike_i = '0;
		cfgWr_i   = '0;
		for (int n = 0; n < NUM_NURNS; n++) begin
			mPot[n] = '0;
			mCfg[n] = '0;
			for (int a = 0; a < NUM_AXONS; a++) begin
				mWeight[n][a] = '0;
			end
		end
		repeat (5) @(negedge clk_i);
		arstN_i = 1'b1;
	endtask

	task automatic writeWeight(input int n, input int a, input potT w);
		@(negedge clk_i);
		cfgWr_i          = '0;
		cfgWr_i.en       = 1'b1;
		cfgWr_i.isWeight = 1'b1;
		cfgWr_i.nurnId   = nurnIdT'(n);
		cfgWr_i.axonId   = axonIdT'(a);
		cfgWr_i.weight   = w;
		mWeight[n][a]    = w;
		@(negedge clk_i);
		cfgWr_i = '0;
	endtask

	task automatic writeParams(input int n, input potT thr, input potT rst, input potT bias);
		@(negedge clk_i);
		cfgWr_i                   = '0;
		cfgWr_i.en                = 1'b1;
		cfgWr_i.nurnId            = nurnIdT'(n);
		cfgWr_i.nurnCfg.threshold = thr;
		cfgWr_i.nurnCfg.rstPot    = rst;
		cfgWr_i.nurnCfg.bias      = bias;
		mCfg[n].threshold         = thr;
		mCfg[n].rstPot            = rst;
		mCfg[n].bias              = bias;
		@(negedge clk_i);
		cfgWr_i = '0;
	endtask

	// weights in [-2, 4), thresholds in [0, 16]
	task automatic randomConfig();
		for (int n = 0; n < NUM_NURNS; n++) begin
			for (int a = 0; a < NUM_AXONS; a++) begin
				writeWeight(n, a, potT'(int'($urandom_range(6 * ONE)) - 2 * ONE));
			end
			writeParams(n, potT'(int'($urandom_range(16 * ONE))),
				potT'(-int'($urandom_range(4 * ONE))),
				potT'(int'($urandom_range(2 * ONE)) - ONE));
		end
	endtask

	// one time step, optionally with a second start_i while busy
	task automatic runStep(input spikeVecT spikes, input bit extraStart);
		int cycles;
		modelStep(spikes);
		gotQ.delete();
		@(negedge clk_i);
		start_i   = 1'b1;
		inSpike_i = spikes;
		@(negedge clk_i);
		start_i   = 1'b0;
		// captured vector is held inside, inputs may move on
		inSpike_i = spikeVecT'($urandom);
		stepCount++;
		if (!busy_o) begin
			failRun("busy_o did not rise after start_i");
		end
		cycles = 0;
		do begin
			@(negedge clk_i);
			cycles++;
			start_i = extraStart && (cycles == 5);
			if (spikeValid_o) begin
				gotQ.push_back(spikePkt_o);
			end
			// busy_o stays high through the step and is low with done_o
			if (busy_o == done_o) begin
				failRun("busy_o did not stay high until done_o and fall with it");
			end
			if (cycles > STEP_BUDGET) begin
				failRun("done_o never arrived, the time step did not finish");
			end
		end while (!done_o);
		if (cycles != STEP_CYCLES) begin
			failRun($sformatf("error %s: step length expected %0d actual %0d",
				curTest, STEP_CYCLES, cycles));
		end
		checkDone(nurnIdT'(expQ.size()), nurnIdT'(gotQ.size()));
		// a full step of NUM_NURNS packets wraps the count above
		if (gotQ.size() != expQ.size()) begin
			failRun($sformatf("error %s: packet count expected %0d actual %0d",
				curTest, expQ.size(), gotQ.size()));
		end
		foreach (expQ[i]) begin
			checkPkt(expQ[i], gotQ[i]);
		end
		if (extraStart) begin
			repeat (3) @(negedge clk_i);
			if (busy_o) begin
				failRun("start_i during a busy step started another step");
			end
		end
	endtask

	//----------------------------------------
	// monitor and watchdog
	//----------------------------------------
	// last packet leaves together with done_o, after busy_o fell
	always @(negedge clk_i) begin
		if (arstN_i) begin
			if (done_o) begin
				doneCount++;
			end
			if (spikeValid_o && !busy_o && !done_o) begin
				failRun("spike packet seen outside a time step");
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		failRun("watchdog expired before the tests finished");
	end

	//----------------------------------------
	// test sequence
	//----------------------------------------
	initial begin
		void'($urandom(SEED));
		clk_i     = 1'b0;
		arstN_i   = 1'b0;
		start_i   = 1'b0;
		inSpike_i = '0;
		cfgWr_i   = '0;
		stepCount = 0;
		doneCount = 0;
		resetDut();

		// zero thresholds, so every neuron fires at 0
		curTest = "resetStep";
		runStep(spikeVecT'($urandom), 1'b0);

		curTest = "randomSteps";
		randomConfig();
		repeat (30) runStep(spikeVecT'($urandom), 1'b0);

		// integrate over steps from a clean state
		curTest = "integrate";
		resetDut();
		for (int n = 0; n < NUM_NURNS; n++) begin
			writeParams(n, potT'(6 * ONE), potT'(-ONE), potT'((n + 1) * ONE));
		end
		repeat (8) runStep(spikeVecT'($urandom), 1'b0);

		// wrapping would flip both firing decisions
		curTest = "saturate";
		resetDut();
		for (int a = 0; a < NUM_AXONS; a++) begin
			writeWeight(0, a, POT_MAX);
			writeWeight(1, a, POT_MIN);
		end
		writeParams(0, POT_MAX, '0, POT_MAX);
		writeParams(1, potT'(int'(POT_MIN) + 1), '0, POT_MIN);
		repeat (2) runStep('1, 1'b0);

		curTest = "startWhileBusy";
		randomConfig();
		repeat (3) runStep(spikeVecT'($urandom), 1'b1);

		curTest = "reconfigOne";
		runStep(spikeVecT'($urandom), 1'b0);
		writeParams(2, POT_MIN, potT'(ONE), '0);
		runStep(spikeVecT'($urandom), 1'b0);

		repeat (10) @(negedge clk_i);
		if (doneCount != stepCount) begin
			failRun($sformatf("error doneCount: expected %0d actual %0d",
				stepCount, doneCount));
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verilog/configMem.sv
//----------------------------------------
// synapse weights and neuron parameters;
// written by cfgWr_i while idle, read
// with one cycle latency during a step
//----------------------------------------
`default_nettype none

module configMem import nurnPkg::*; (
	input  logic    clk_i,
	input  logic    arstN_i,
	input  cfgWrT   cfgWr_i,
	input  logic    busy_i,
	input  nurnIdT  nurnId_i,
	input  axonIdT  axonId_i,
	output potT     weight_o,
	output nurnCfgT nurnCfg_o
);

	potT     weightMem [NUM_NURNS][NUM_AXONS];
	nurnCfgT paramMem [NUM_NURNS];

	//----------------------------------------
	// write port
	//----------------------------------------
	always_ff @(posedge clk_i or negedge arstN_i) begin
		if (!arstN_i) begin
			for (int n = 0; n < NUM_NURNS; n++) begin
				paramMem[n] <= '0;
				for (int a = 0; a < NUM_AXONS; a++) begin
					weightMem[n][a] <= '0;
				end
			end
		end else if (cfgWr_i.en) begin
			if (cfgWr_i.isWeight) begin
				weightMem[cfgWr_i.nurnId][cfgWr_i.axonId] <= cfgWr_i.weight;
			end else begin
				paramMem[cfgWr_i.nurnId] <= cfgWr_i.nurnCfg;
			end
		end
	end

	//----------------------------------------
	// read ports
	//----------------------------------------
	always_ff @(posedge clk_i) begin
		weight_o  <= weightMem[nurnId_i][axonId_i];
		nurnCfg_o <= paramMem[nurnId_i];
	end

	// the datapath reads the parameters late in a neuron, so they must hold still
	noCfgWhileBusy: assert property (@(posedge clk_i) disable iff (!arstN_i)
		!(cfgWr_i.en && busy_i))
		else $error("configuration write during a time step");

endmodule

`default_nettype wire

// File: verilog/dataPath.sv
//----------------------------------------
// neuron arithmetic; saturating sum of
// potential, bias and active weights,
// threshold test, write-back and packet
//----------------------------------------
`default_nettype none

module dataPath import nurnPkg::*; (
	input  logic     clk_i,
	input  logic     arstN_i,
	input  potT      pot_i,
	input  nurnCfgT  nurnCfg_i,
	input  potT      weight_i,
	input  logic     spike_i,
	input  logic     loadAcc_i,
	input  logic     accEn_i,
	input  logic     fire_i,
	input  nurnIdT   nurnId_i,
	output logic     wrEn_o,
	output potT      pot_o,
	output logic     spikeValid_o,
	output spikePktT spikePkt_o
);

	potT                   acc;
	potT                   addA;
	potT                   addB;
	potT                   sum;
	logic signed [DSIZE:0] wideSum;
	nurnIdT                curNurn;
	logic                  fired;

	//----------------------------------------
	// saturating adder
	//----------------------------------------
	// one adder, potential plus bias on load, else acc plus weight
	always_comb begin
		addA = loadAcc_i ? pot_i : acc;
		if (loadAcc_i) begin
			addB = nurnCfg_i.bias;
		end else if (spike_i) begin
			addB = weight_i;
		end else begin
			addB = '0;
		end
		wideSum = {addA[DSIZE-1], addA} + {addB[DSIZE-1], addB};
		// sign and carry disagree on overflow
		if (wideSum[DSIZE] != wideSum[DSIZE-1]) begin
			sum = wideSum[DSIZE] ? POT_MIN : POT_MAX;
		end else begin
			sum = potT'(wideSum[DSIZE-1:0]);
		end
	end

	// config read is still the current neuron's in FIRE
	assign fired = (acc >= nurnCfg_i.threshold);

	always_ff @(posedge clk_i) begin
		if (loadAcc_i || accEn_i) begin
			acc <= sum;
		end
		// address moves on in FIRE, so keep the neuron id
		if (loadAcc_i) begin
			curNurn <= nurnId_i;
		end
		if (fire_i) begin
			pot_o      <= fired ? nurnCfg_i.rstPot : acc;
			spikePkt_o <= '{coreX: CORE_X, coreY: CORE_Y, reserved: '0, nurnId: curNurn};
		end
	end

	//----------------------------------------
	// strobes
	//----------------------------------------
	always_ff @(posedge clk_i or negedge arstN_i) begin
		if (!arstN_i) begin
			wrEn_o       <= 1'b0;
			spikeValid_o <= 1'b0;
		end else begin
			wrEn_o       <= fire_i;
			spikeValid_o <= fire_i && fired;
		end
	end

	// the adder operand select expects one strobe at a time
	strobesExclusive: assert property (@(posedge clk_i) disable iff (!arstN_i)
		$onehot0({loadAcc_i, accEn_i, fire_i}))
		else $error("more than one datapath strobe at once");

endmodule

`default_nettype wire

// File: verilog/inSpikeBuf.sv
//----------------------------------------
// input spike buffer; holds the axon
// spikes of the running step so the core
// inputs are free to change meanwhile
//----------------------------------------
`default_nettype none

module inSpikeBuf import nurnPkg::*; (
	input  logic     clk_i,
	input  logic     arstN_i,
	input  logic     capture_i,
	input  spikeVecT inSpike_i,
	input  axonIdT   axonId_i,
	output logic     spike_o
);

	spikeVecT spikeReg;

	always_ff @(posedge clk_i or negedge arstN_i) begin
		if (!arstN_i) begin
			spikeReg <= '0;
			spike_o  <= 1'b0;
		end else begin
			if (capture_i) begin
				spikeReg <= inSpike_i;
			end
			// per-axon read, one cycle behind the address
			spike_o <= spikeReg[axonId_i];
		end
	end

	cleanCapture: assert property (@(posedge clk_i) disable iff (!arstN_i)
		capture_i |-> !$isunknown(inSpike_i))
		else $error("spike vector has unknown bits at step start");

endmodule

`default_nettype wire

// File: verilog/neuronCore.sv
//----------------------------------------
// spiking neuron core; pulse start_i to
// run one time step, packets leave on
// spikeValid_o and done_o ends the step
//----------------------------------------
`default_nettype none

module neuronCore import nurnPkg::*; (
	input  logic     clk_i,
	input  logic     arstN_i,
	input  logic     start_i,
	input  spikeVecT inSpike_i,
	input  cfgWrT    cfgWr_i,
	output logic     busy_o,
	output logic     done_o,
	output logic     spikeValid_o,
	output spikePktT spikePkt_o
);

	logic    capture;
	nurnIdT  nurnId;
	axonIdT  axonId;
	logic    loadAcc;
	logic    accEn;
	logic    fire;
	logic    spike;
	potT     weight;
	nurnCfgT nurnCfg;
	potT     rdPot;
	logic    wrEn;
	potT     wrPot;

	//----------------------------------------
	// input side
	//----------------------------------------
	inSpikeBuf inSpikeBuf_i (
		.clk_i     (clk_i),
		.arstN_i   (arstN_i),
		.capture_i (capture),
		.inSpike_i (inSpike_i),
		.axonId_i  (axonId),
		.spike_o   (spike)
	);

	nurnCtrlr nurnCtrlr_i (
		.clk_i     (clk_i),
		.arstN_i   (arstN_i),
		.start_i   (start_i),
		.capture_o (capture),
		.nurnId_o  (nurnId),
		.axonId_o  (axonId),
		.loadAcc_o (loadAcc),
		.accEn_o   (accEn),
		.fire_o    (fire),
		.busy_o    (busy_o),
		.done_o    (done_o)
	);

	//----------------------------------------
	// memories
	//----------------------------------------
	configMem configMem_i (
		.clk_i     (clk_i),
		.arstN_i   (arstN_i),
		.cfgWr_i   (cfgWr_i),
		.busy_i    (busy_o),
		.nurnId_i  (nurnId),
		.axonId_i  (axonId),
		.weight_o  (weight),
		.nurnCfg_o (nurnCfg)
	);

	// write-back goes to the neuron named in the last packet register
	statusMem statusMem_i (
		.clk_i    (clk_i),
		.arstN_i  (arstN_i),
		.rdNurn_i (nurnId),
		.pot_o    (rdPot),
		.wrEn_i   (wrEn),
		.wrNurn_i (spikePkt_o.nurnId),
		.pot_i    (wrPot)
	);

	dataPath dataPath_i (
		.clk_i        (clk_i),
		.arstN_i      (arstN_i),
		.pot_i        (rdPot),
		.nurnCfg_i    (nurnCfg),
		.weight_i     (weight),
		.spike_i      (spike),
		.loadAcc_i    (loadAcc),
		.accEn_i      (accEn),
		.fire_i       (fire),
		.nurnId_i     (nurnId),
		.wrEn_o       (wrEn),
		.pot_o        (wrPot),
		.spikeValid_o (spikeValid_o),
		.spikePkt_o   (spikePkt_o)
	);

endmodule

`default_nettype wire

// File: verilog/nurnCtrlr.sv
//----------------------------------------
// time-step sequencer; walks the neurons
// in order and the axons of each, giving
// memory addresses a cycle ahead of the
// matching datapath strobe
//----------------------------------------
`default_nettype none

module nurnCtrlr import nurnPkg::*; (
	input  logic   clk_i,
	input  logic   arstN_i,
	input  logic   start_i,
	output logic   capture_o,
	output nurnIdT nurnId_o,
	output axonIdT axonId_o,
	output logic   loadAcc_o,
	output logic   accEn_o,
	output logic   fire_o,
	output logic   busy_o,
	output logic   done_o
);

	ctrlStateT state;
	nurnIdT    nurnCnt;
	axonIdT    axonCnt;

	//----------------------------------------
	// state machine
	//----------------------------------------
	// LOAD addresses axon 0, ACCUM k addresses axon k+1, so the axon
	// counter wraps to 0 in the last ACCUM; likewise the neuron counter
	// steps on entering FIRE and is 0 again after the last neuron
	always_ff @(posedge clk_i or negedge arstN_i) begin
		if (!arstN_i) begin
			state   <= IDLE;
			nurnCnt <= '0;
			axonCnt <= '0;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				IDLE: begin
					if (start_i) begin
						state <= LOAD;
					end
				end
				LOAD: begin
					state   <= ACCUM;
					axonCnt <= axonCnt + axonIdT'(1);
				end
				ACCUM: begin
					if (axonCnt == '0) begin
						state   <= FIRE;
						nurnCnt <= nurnCnt + nurnIdT'(1);
					end else begin
						axonCnt <= axonCnt + axonIdT'(1);
					end
				end
				FIRE: begin
					// last neuron done, its packet shows with done_o
					if (nurnCnt == '0) begin
						state  <= IDLE;
						done_o <= 1'b1;
					end else begin
						state <= LOAD;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	//----------------------------------------
	// outputs
	//----------------------------------------
	// neuron 0 is addressed while idle, so its data is ready in LOAD
	assign nurnId_o  = nurnCnt;
	assign axonId_o  = axonCnt;
	assign capture_o = start_i && (state == IDLE);
	assign busy_o    = (state != IDLE);
	assign loadAcc_o = (state == LOAD);
	assign accEn_o   = (state == ACCUM);
	assign fire_o    = (state == FIRE);

	// LOAD and FIRE need the axon counter wrapped back to 0
	axonAligned: assert property (@(posedge clk_i) disable iff (!arstN_i)
		(loadAcc_o || fire_o) |-> (axonId_o == '0))
		else $error("axon counter out of step with the neuron sequence");

endmodule

`default_nettype wire

// File: verilog/nurnPkg.sv
//----------------------------------------
// sizes, core id and shared types of the
// neuron core; modules take them with a
// wildcard import of nurnPkg
//----------------------------------------
`default_nettype none

package nurnPkg;

	//----------------------------------------
	// sizes
	//----------------------------------------
	localparam int NUM_NURNS = 4;
	localparam int NUM_AXONS = 8;
	// 8 integer bits, 8 fraction bits
	localparam int DSIZE = 16;

	typedef logic [7:0] coordT;
	typedef logic signed [DSIZE-1:0] potT;
	typedef logic [$clog2(NUM_NURNS)-1:0] nurnIdT;
	typedef logic [$clog2(NUM_AXONS)-1:0] axonIdT;
	typedef logic [NUM_AXONS-1:0] spikeVecT;

	// position of this core in the mesh
	localparam coordT CORE_X = 8'd1;
	localparam coordT CORE_Y = 8'd1;

	// saturation limits of the fixed-point range
	localparam potT POT_MAX = {1'b0, {(DSIZE-1){1'b1}}};
	localparam potT POT_MIN = {1'b1, {(DSIZE-1){1'b0}}};

	//----------------------------------------
	// structs
	//----------------------------------------
	typedef struct packed {
		potT threshold;
		potT rstPot;
		potT bias;
	} nurnCfgT;

	// isWeight picks the weight array, else the neuron parameters
	typedef struct packed {
		logic    en;
		logic    isWeight;
		nurnIdT  nurnId;
		axonIdT  axonId;
		potT     weight;
		nurnCfgT nurnCfg;
	} cfgWrT;

	// 32-bit address event
	typedef struct packed {
		coordT       coreX;
		coordT       coreY;
		logic [13:0] reserved;
		nurnIdT      nurnId;
	} spikePktT;

	typedef enum logic [1:0] {IDLE, LOAD, ACCUM, FIRE} ctrlStateT;

endpackage

`default_nettype wire

// File: verilog/statusMem.sv
//----------------------------------------
// membrane potential of every neuron,
// kept across steps; cleared by reset
//----------------------------------------
`default_nettype none

module statusMem import nurnPkg::*; (
	input  logic   clk_i,
	input  logic   arstN_i,
	input  nurnIdT rdNurn_i,
	output potT    pot_o,
	input  logic   wrEn_i,
	input  nurnIdT wrNurn_i,
	input  potT    pot_i
);

	potT potMem [NUM_NURNS];

	always_ff @(posedge clk_i or negedge arstN_i) begin
		if (!arstN_i) begin
			for (int n = 0; n < NUM_NURNS; n++) begin
				potMem[n] <= '0;
			end
		end else if (wrEn_i) begin
			potMem[wrNurn_i] <= pot_i;
		end
	end

	// registered read
	always_ff @(posedge clk_i) begin
		pot_o <= potMem[rdNurn_i];
	end

	// write-back trails the controller address by a neuron
	noRdWrClash: assert property (@(posedge clk_i) disable iff (!arstN_i)
		wrEn_i |-> (rdNurn_i != wrNurn_i))
		else $error("potential read and written for the same neuron");

endmodule

`default_nettype wire
